// ==== hw/fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// first bundle fetched after reset
`define FETCH_RESET_PC 32'hbfc0_0000

// predictor table size, power of two
`define FETCH_BPB_ENTRIES 16

`endif

// ==== hw/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] word_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } bpb_result_t;

    // one decode slot
    typedef struct packed {
        word_t       instr;
        word_t       pcplus4;
        logic        en;
        logic        exception_instr;
        bpb_result_t pred;
    } fetch_slot_t;

    typedef enum logic [2:0] {
        s_idle,
        s_req,
        s_wait,
        s_hold,
        s_drain
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== hw/ibus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ibus_if;

    logic             req;
    fetch_pkg::word_t addr;
    logic             data_ok;
    logic [63:0]      data;
    logic             index;

    modport controller (output req, output addr, input data_ok);

    // req lets the fetch side tell a live reply from a drained one
    modport fetch (input req, input data_ok, input data, input index);

    modport top (input req, input addr, output data_ok, output data, output index);

endinterface

`default_nettype wire

// ==== hw/pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module pc_gen (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   flush,
    input  fetch_pkg::word_t       flush_pc,
    input  fetch_pkg::bpb_result_t pred_sel,
    output fetch_pkg::word_t       pc,
    output fetch_pkg::word_t       pcplus4,
    output fetch_pkg::word_t       pcplus8
);

    fetch_pkg::word_t pc_reg;
    fetch_pkg::word_t next_pc;

    always_comb
    begin
        if (flush)
            next_pc = flush_pc;
        else if (pred_sel.taken)
            next_pc = pred_sel.target;
        else if (pc_reg[2])
            next_pc = pc_reg + 32'd4;
        else
            next_pc = pc_reg + 32'd8;
    end

    // new bundle pc is visible in the load cycle itself
    assign pc      = stall ? pc_reg : next_pc;
    assign pcplus4 = pc + 32'd4;
    assign pcplus8 = pc + 32'd8;

    always_ff @(posedge clk)
    begin
        if (reset)
            // one bundle back, so the first load lands on the reset pc
            pc_reg <= `FETCH_RESET_PC - 32'd8;
        else if (~stall)
            pc_reg <= next_pc;
    end

endmodule

`default_nettype wire

// ==== hw/fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic             decode_ready,
    input  logic             finish_instr,
    input  fetch_pkg::word_t pc,
    ibus_if.controller       bus,
    output logic             stall,
    output logic             fetch_valid
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t state_next;

    // no request goes out for a pc that is being flushed
    assign bus.req  = (state == fetch_pkg::s_req) & ~flush;
    assign bus.addr = pc;

    assign fetch_valid = (state != fetch_pkg::s_drain) & finish_instr;

    always_comb
    begin
        state_next = state;
        stall      = 1'b1;
        case (state)
            fetch_pkg::s_idle:
            begin
                stall      = 1'b0;
                state_next = fetch_pkg::s_req;
            end
            fetch_pkg::s_req:
            begin
                stall = ~flush;
                if (~flush)
                    state_next = fetch_pkg::s_wait;
            end
            fetch_pkg::s_wait:
            begin
                if (flush)
                begin
                    stall      = 1'b0;
                    // reply still outstanding unless it is here now
                    state_next = bus.data_ok ? fetch_pkg::s_req : fetch_pkg::s_drain;
                end
                else if (bus.data_ok)
                begin
                    stall      = ~decode_ready;
                    state_next = decode_ready ? fetch_pkg::s_req : fetch_pkg::s_hold;
                end
            end
            fetch_pkg::s_hold:
            begin
                stall = ~(flush | decode_ready);
                if (flush | decode_ready)
                    state_next = fetch_pkg::s_req;
            end
            fetch_pkg::s_drain:
            begin
                // a second flush only moves the pc
                stall = ~flush;
                if (bus.data_ok)
                    state_next = fetch_pkg::s_req;
            end
            default:
                state_next = fetch_pkg::s_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= fetch_pkg::s_idle;
        else
            state <= state_next;
    end

endmodule

`default_nettype wire

// ==== hw/branch_predict_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module branch_predict_buf (
    input  logic                         clk,
    input  logic                         reset,
    input  fetch_pkg::word_t             lookup_pc,
    output fetch_pkg::bpb_result_t [1:0] result,
    input  logic                         resolve_valid,
    input  logic                         resolve_taken,
    input  fetch_pkg::word_t             resolve_pc,
    input  fetch_pkg::word_t             resolve_target
);

    localparam int IDX_W = $clog2(`FETCH_BPB_ENTRIES);
    localparam int TAG_W = 30 - IDX_W;

    logic [`FETCH_BPB_ENTRIES-1:0] valid;
    logic [`FETCH_BPB_ENTRIES-1:0] taken;
    logic [TAG_W-1:0]              tag_mem    [`FETCH_BPB_ENTRIES];
    fetch_pkg::word_t              target_mem [`FETCH_BPB_ENTRIES];

    logic [IDX_W-1:0]              wr_idx;
    fetch_pkg::word_t [1:0]        rd_pc;
    logic [1:0][IDX_W-1:0]         rd_idx;
    logic [1:0]                    hit;

    assign wr_idx = resolve_pc[IDX_W+1:2];

    // slot 1 is the bundle pc, slot 0 the word after it
    assign rd_pc[1] = lookup_pc;
    assign rd_pc[0] = lookup_pc + 32'd4;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid <= '0;
            taken <= '0;
        end
        else if (resolve_valid)
        begin
            valid[wr_idx] <= 1'b1;
            taken[wr_idx] <= resolve_taken;
        end
    end

    always_ff @(posedge clk)
    begin
        if (resolve_valid)
        begin
            tag_mem[wr_idx]    <= resolve_pc[31:IDX_W+2];
            target_mem[wr_idx] <= resolve_target;
        end
    end

    always_comb
    begin
        for (int k = 0; k < 2; k++)
        begin
            rd_idx[k]        = rd_pc[k][IDX_W+1:2];
            hit[k]           = valid[rd_idx[k]] && (tag_mem[rd_idx[k]] == rd_pc[k][31:IDX_W+2]);
            result[k].taken  = hit[k] & taken[rd_idx[k]];
            result[k].target = hit[k] ? target_mem[rd_idx[k]] : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/instr_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_fetch (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stall,
    input  logic                         flush,
    input  fetch_pkg::word_t             pc_pcf,
    input  fetch_pkg::word_t             pcplus4_pcf,
    input  fetch_pkg::word_t             pcplus8_pcf,
    ibus_if.fetch                        bus,
    output fetch_pkg::fetch_slot_t [1:0] fetch_data,
    output logic                         finish_instr,
    input  fetch_pkg::bpb_result_t [1:0] destpc_predict_in,
    output fetch_pkg::bpb_result_t       destpc_predict_sel
);

    logic                         live;
    logic                         reply_ok;
    logic                         finish_his;
    logic                         ien_his;
    logic [1:0]                   ien;
    logic [1:0]                   hit;
    logic [63:0]                  data_his;
    logic [63:0]                  data;
    logic                         exception_instr;
    fetch_pkg::word_t             pc;
    fetch_pkg::word_t             pcplus4;
    fetch_pkg::word_t             pcplus8;
    fetch_pkg::bpb_result_t [1:0] pred;
    fetch_pkg::bpb_result_t       last_predict;
    fetch_pkg::bpb_result_t       next_predict;

    // a reply counts only if its request was issued after the last load
    assign reply_ok = bus.data_ok & live;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            live         <= 1'b0;
            finish_his   <= 1'b0;
            ien_his      <= 1'b1;
            pred         <= '0;
            last_predict <= '0;
        end
        else
        begin
            if (bus.req)
                live <= 1'b1;
            if (reply_ok)
            begin
                finish_his <= 1'b1;
                ien_his    <= ~bus.index;
            end
            if (~stall)
            begin
                live       <= 1'b0;
                finish_his <= 1'b0;
                pred       <= destpc_predict_in;
            end
            if (flush)
                last_predict <= '0;
            else if (~stall)
                last_predict <= next_predict;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reply_ok)
            data_his <= bus.data;
        if (~stall)
        begin
            pc      <= pc_pcf;
            pcplus4 <= pcplus4_pcf;
            pcplus8 <= pcplus8_pcf;
        end
    end

    // bypass the reply in its own cycle
    assign data         = reply_ok ? bus.data : data_his;
    assign ien          = {1'b1, reply_ok ? ~bus.index : ien_his};
    assign finish_instr = finish_his | reply_ok;

    // only the delay slot survives a carried prediction
    assign hit = {ien[1], ien[0] & ~last_predict.taken};

    assign exception_instr = (pc[1:0] != 2'b00);

    assign fetch_data[1].instr           = ien[0] ? data[31:0] : data[63:32];
    assign fetch_data[0].instr           = ien[0] ? data[63:32] : '0;
    assign fetch_data[1].pcplus4         = pcplus4;
    assign fetch_data[0].pcplus4         = pcplus8;
    assign fetch_data[1].en              = hit[1];
    assign fetch_data[0].en              = hit[0];
    assign fetch_data[1].exception_instr = exception_instr;
    assign fetch_data[0].exception_instr = exception_instr;
    assign fetch_data[1].pred            = pred[1];
    assign fetch_data[0].pred            = hit[0] ? pred[0] : '0;

    always_comb
    begin
        if (last_predict.taken)
            destpc_predict_sel = last_predict;
        else if (pred[1].taken & ien[0])
            destpc_predict_sel = pred[1];
        else
            destpc_predict_sel = '0;
    end

    // branch in the last slot, its delay slot comes with the next bundle
    always_comb
    begin
        if (last_predict.taken)
            next_predict = '0;
        else if (ien[0])
            next_predict = pred[1].taken ? '0 : pred[0];
        else
            next_predict = pred[1];
    end

endmodule

`default_nettype wire

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  fetch_pkg::word_t       flush_pc,
    output logic                   ibus_req,
    output fetch_pkg::word_t       ibus_addr,
    input  logic                   ibus_data_ok,
    input  logic [63:0]            ibus_data,
    input  logic                   ibus_index,
    input  logic                   decode_ready,
    output logic                   fetch_valid,
    output logic [1:0]             slot_en,
    output fetch_pkg::word_t [1:0] slot_instr,
    output fetch_pkg::word_t [1:0] slot_pcplus4,
    output logic [1:0]             slot_pred_taken,
    output logic [1:0]             slot_exception,
    input  logic                   resolve_valid,
    input  fetch_pkg::word_t       resolve_pc,
    input  logic                   resolve_taken,
    input  fetch_pkg::word_t       resolve_target
);

    fetch_pkg::word_t             pc;
    fetch_pkg::word_t             pcplus4;
    fetch_pkg::word_t             pcplus8;
    logic                         stall;
    logic                         finish_instr;
    fetch_pkg::bpb_result_t       pred_sel;
    fetch_pkg::bpb_result_t [1:0] bpb_result;
    fetch_pkg::fetch_slot_t [1:0] fetch_data;

    ibus_if ibus ();

    assign ibus_req     = ibus.req;
    assign ibus_addr    = ibus.addr;
    assign ibus.data_ok = ibus_data_ok;
    assign ibus.data    = ibus_data;
    assign ibus.index   = ibus_index;

    pc_gen u_pc_gen (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .flush    (flush),
        .flush_pc (flush_pc),
        .pred_sel (pred_sel),
        .pc       (pc),
        .pcplus4  (pcplus4),
        .pcplus8  (pcplus8)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .decode_ready (decode_ready),
        .finish_instr (finish_instr),
        .pc           (pc),
        .bus          (ibus.controller),
        .stall        (stall),
        .fetch_valid  (fetch_valid)
    );

    branch_predict_buf u_branch_predict_buf (
        .clk            (clk),
        .reset          (reset),
        .lookup_pc      (pc),
        .result         (bpb_result),
        .resolve_valid  (resolve_valid),
        .resolve_taken  (resolve_taken),
        .resolve_pc     (resolve_pc),
        .resolve_target (resolve_target)
    );

    instr_fetch u_instr_fetch (
        .clk                (clk),
        .reset              (reset),
        .stall              (stall),
        .flush              (flush),
        .pc_pcf             (pc),
        .pcplus4_pcf        (pcplus4),
        .pcplus8_pcf        (pcplus8),
        .bus                (ibus.fetch),
        .fetch_data         (fetch_data),
        .finish_instr       (finish_instr),
        .destpc_predict_in  (bpb_result),
        .destpc_predict_sel (pred_sel)
    );

    // slot structs out as plain ports
    always_comb
    begin
        for (int k = 0; k < 2; k++)
        begin
            slot_en[k]         = fetch_data[k].en;
            slot_instr[k]      = fetch_data[k].instr;
            slot_pcplus4[k]    = fetch_data[k].pcplus4;
            slot_pred_taken[k] = fetch_data[k].pred.taken;
            slot_exception[k]  = fetch_data[k].exception_instr;
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module tb_fetch_top;

    localparam int NUM_TESTS      = 6;
    localparam int MAX_BUNDLES    = 40;
    localparam int CYC_PER_BUNDLE = 8;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * MAX_BUNDLES * CYC_PER_BUNDLE;

    logic                   clk;
    logic                   reset;
    logic                   flush;
    fetch_pkg::word_t       flush_pc;
    logic                   ibus_req;
    fetch_pkg::word_t       ibus_addr;
    logic                   ibus_data_ok = 1'b0;
    logic [63:0]            ibus_data = '0;
    logic                   ibus_index = 1'b0;
    logic                   decode_ready = 1'b0;
    logic                   fetch_valid;
    logic [1:0]             slot_en;
    fetch_pkg::word_t [1:0] slot_instr;
    fetch_pkg::word_t [1:0] slot_pcplus4;
    logic [1:0]             slot_pred_taken;
    logic [1:0]             slot_exception;
    logic                   resolve_valid;
    fetch_pkg::word_t       resolve_pc;
    logic                   resolve_taken;
    fetch_pkg::word_t       resolve_target;

    // test bookkeeping
    string       test_name = "reset";
    int          errors = 0;
    int          checks = 0;
    int          test_err_start = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          cycles = 0;
    int          consumed = 0;
    int          drained = 0;
    int          pred1_seen = 0;
    int          delay_only_seen = 0;
    logic        ready_random = 1'b0;
    logic        slow_reply = 1'b0;
    int unsigned seed_dummy;

    // reference model state
    fetch_pkg::word_t exp_pc;
    logic             carry_taken;
    fetch_pkg::word_t carry_tgt;
    logic             idle_check = 1'b0;
    logic             first_req_seen = 1'b0;
    fetch_pkg::word_t first_req_addr;
    fetch_pkg::word_t bp_pc  [4];
    fetch_pkg::word_t bp_tgt [4];
    int               bp_n = 0;

    // held bundle snapshot
    logic             held = 1'b0;
    logic [1:0]       snap_en;
    logic [63:0]      snap_instr;
    logic [63:0]      snap_pc4;
    logic [1:0]       snap_pred;
    logic [1:0]       snap_exc;

    // memory responder state
    logic             pend = 1'b0;
    fetch_pkg::word_t pend_addr;
    int               pend_epoch;
    int               wait_left;
    int               resp_epoch = 0;
    int               flush_epoch = 0;

    fetch_top u_fetch_top (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .flush_pc        (flush_pc),
        .ibus_req        (ibus_req),
        .ibus_addr       (ibus_addr),
        .ibus_data_ok    (ibus_data_ok),
        .ibus_data       (ibus_data),
        .ibus_index      (ibus_index),
        .decode_ready    (decode_ready),
        .fetch_valid     (fetch_valid),
        .slot_en         (slot_en),
        .slot_instr      (slot_instr),
        .slot_pcplus4    (slot_pcplus4),
        .slot_pred_taken (slot_pred_taken),
        .slot_exception  (slot_exception),
        .resolve_valid   (resolve_valid),
        .resolve_pc      (resolve_pc),
        .resolve_taken   (resolve_taken),
        .resolve_target  (resolve_target)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic fetch_pkg::word_t mem_word(input fetch_pkg::word_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    // trained branches, matched on the word address
    function automatic logic [32:0] lookup_pred(input fetch_pkg::word_t pc);
        logic [32:0] res;
        res = '0;
        for (int k = 0; k < bp_n; k++)
            if (bp_pc[k][31:2] == pc[31:2])
                res = {1'b1, bp_tgt[k]};
        return res;
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act)
        else
        begin
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bundle();
        logic             idx;
        logic             en0;
        logic [32:0]      p1;
        logic [32:0]      p0;
        fetch_pkg::word_t base;
        idx  = exp_pc[2];
        p1   = lookup_pred(exp_pc);
        p0   = lookup_pred(exp_pc + 32'd4);
        en0  = ~idx & ~carry_taken;
        base = exp_pc & ~32'd7;
        check_val("slot1 en", 32'd1, {31'd0, slot_en[1]});
        check_val("slot0 en", {31'd0, en0}, {31'd0, slot_en[0]});
        check_val("slot1 instr", idx ? mem_word(base + 32'd4) : mem_word(base), slot_instr[1]);
        check_val("slot1 pcplus4", exp_pc + 32'd4, slot_pcplus4[1]);
        check_val("slot1 pred", {31'd0, p1[32]}, {31'd0, slot_pred_taken[1]});
        check_val("slot0 pred", {31'd0, en0 & p0[32]}, {31'd0, slot_pred_taken[0]});
        check_val("exception", {2{exp_pc[1:0] != 2'b00}}, {30'd0, slot_exception});
        if (en0)
        begin
            check_val("slot0 instr", mem_word(base + 32'd4), slot_instr[0]);
            check_val("slot0 pcplus4", exp_pc + 32'd8, slot_pcplus4[0]);
        end
        if (p1[32] && slot_pred_taken[1] && slot_en[0])
            pred1_seen++;
        if (carry_taken && !slot_en[0])
            delay_only_seen++;
        // next bundle pc
        if (carry_taken)
        begin
            exp_pc      = carry_tgt;
            carry_taken = 1'b0;
        end
        else if (en0 && p1[32])
            exp_pc = p1[31:0];
        else if (en0)
        begin
            carry_taken = p0[32];
            carry_tgt   = p0[31:0];
            exp_pc      = exp_pc + 32'd8;
        end
        else
        begin
            carry_taken = p1[32];
            carry_tgt   = p1[31:0];
            exp_pc      = exp_pc + 32'd4;
        end
        consumed++;
    endtask

    // monitor and reference model, sampled before the edge updates
    always @(posedge clk)
    begin
        if (reset)
        begin
            // outputs are unknown until the first reset edge
            if (idle_check)
            begin
                assert (!ibus_req && !fetch_valid)
                else
                begin
                    $display("ibus_req or fetch_valid high during reset");
                    errors++;
                end
            end
            exp_pc      = `FETCH_RESET_PC;
            carry_taken = 1'b0;
            idle_check  = 1'b1;
            held        = 1'b0;
        end
        else
        begin
            if (idle_check)
            begin
                assert (!ibus_req && !fetch_valid)
                else
                begin
                    $display("ibus_req or fetch_valid high in the cycle after reset");
                    errors++;
                end
                idle_check = 1'b0;
            end
            if (ibus_req && !first_req_seen)
            begin
                first_req_seen = 1'b1;
                first_req_addr = ibus_addr;
            end
            if (held && !flush)
            begin
                assert (snap_en == slot_en && snap_instr == slot_instr &&
                        snap_pc4 == slot_pcplus4 && snap_pred == slot_pred_taken &&
                        snap_exc == slot_exception && fetch_valid)
                else
                begin
                    $display("%s: fetch outputs changed while decode held them", test_name);
                    errors++;
                end
            end
            held = 1'b0;
            if (ibus_data_ok && resp_epoch != flush_epoch && !flush)
            begin
                if (!fetch_valid)
                    drained++;
                assert (!fetch_valid)
                else
                begin
                    $display("%s: reply of a flushed request reached decode", test_name);
                    errors++;
                end
            end
            if (flush)
            begin
                exp_pc      = flush_pc;
                carry_taken = 1'b0;
                flush_epoch <= flush_epoch + 1;
            end
            else if (fetch_valid && decode_ready)
                check_bundle();
            else if (fetch_valid)
            begin
                held       = 1'b1;
                snap_en    = slot_en;
                snap_instr = slot_instr;
                snap_pc4   = slot_pcplus4;
                snap_pred  = slot_pred_taken;
                snap_exc   = slot_exception;
            end
        end
    end

    // memory responder: take the request at the edge, answer on a falling edge
    always @(posedge clk)
    begin
        if (reset)
            pend = 1'b0;
        else if (ibus_req)
        begin
            assert (!pend)
            else
            begin
                $display("second bus request while one was outstanding");
                errors++;
            end
            pend       = 1'b1;
            pend_addr  = ibus_addr;
            pend_epoch = flush_epoch;
            wait_left  = slow_reply ? 2 : $urandom % 4;
        end
    end

    always @(negedge clk)
    begin
        ibus_data_ok = 1'b0;
        if (pend)
        begin
            if (wait_left == 0)
            begin
                ibus_data_ok = 1'b1;
                ibus_data    = {mem_word((pend_addr & ~32'd7) + 32'd4),
                                mem_word(pend_addr & ~32'd7)};
                ibus_index   = pend_addr[2];
                resp_epoch   = pend_epoch;
                pend         = 1'b0;
            end
            else
                wait_left--;
        end
        decode_ready = ready_random ? ($urandom % 3 != 0) : 1'b1;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
        begin
            $display("timeout: run exceeded %0d cycles in test %s", TIMEOUT_CYCLES, test_name);
            $display("sim failed");
            $finish;
        end
    end

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        if (errors == test_err_start)
        begin
            pass_cnt++;
            $display("test %s: pass", test_name);
        end
        else
        begin
            fail_cnt++;
            $display("test %s: FAIL, %0d errors", test_name, errors - test_err_start);
        end
    endtask

    task automatic run_bundles(input int n);
        int target;
        target = consumed + n;
        while (consumed < target)
            @(posedge clk);
    endtask

    task automatic flush_to(input fetch_pkg::word_t pc);
        @(negedge clk);
        flush    = 1'b1;
        flush_pc = pc;
        @(negedge clk);
        flush    = 1'b0;
    endtask

    task automatic train_branch(input fetch_pkg::word_t pc, input fetch_pkg::word_t target);
        @(negedge clk);
        resolve_valid  = 1'b1;
        resolve_pc     = pc;
        resolve_taken  = 1'b1;
        resolve_target = target;
        bp_pc[bp_n]    = pc;
        bp_tgt[bp_n]   = target;
        bp_n++;
        @(negedge clk);
        resolve_valid  = 1'b0;
    endtask

    initial
    begin
        seed_dummy     = $urandom(32'ha0b6);
        reset          = 1'b1;
        flush          = 1'b0;
        flush_pc       = '0;
        resolve_valid  = 1'b0;
        resolve_pc     = '0;
        resolve_taken  = 1'b0;
        resolve_target = '0;
        start_test("reset");
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        wait (first_req_seen);
        check_val("first ibus_addr", `FETCH_RESET_PC, first_req_addr);
        end_test();

        start_test("sequential");
        run_bundles(10);
        end_test();

        start_test("unaligned");
        flush_to(32'h0000_2004);
        run_bundles(3);
        flush_to(32'h0000_3002);
        run_bundles(2);
        end_test();

        start_test("backpressure");
        ready_random = 1'b1;
        flush_to(32'h0000_1000);
        run_bundles(24);
        ready_random = 1'b0;
        end_test();

        start_test("branch_first_slot");
        train_branch(32'h0000_5000, 32'h0000_6000);
        flush_to(32'h0000_4ff0);
        run_bundles(6);
        assert (pred1_seen > 0)
        else
        begin
            $display("%s: no bundle showed a prediction in slot 1", test_name);
            errors++;
        end
        end_test();

        start_test("branch_last_slot_drain");
        // index of this branch differs from the first one
        train_branch(32'h0000_7004, 32'h0000_8000);
        flush_to(32'h0000_6ff8);
        run_bundles(5);
        assert (delay_only_seen > 0)
        else
        begin
            $display("%s: no delay-slot-only bundle was delivered", test_name);
            errors++;
        end
        slow_reply = 1'b1;
        do
            @(posedge clk);
        while (!ibus_req);
        flush_to(32'h0000_9000);
        run_bundles(4);
        slow_reply = 1'b0;
        assert (drained > 0)
        else
        begin
            $display("%s: no reply of a flushed request was dropped", test_name);
            errors++;
        end
        end_test();

        $display("tests: %0d passed, %0d failed, %0d checks, %0d errors",
                 pass_cnt, fail_cnt, checks, errors);
        if (errors == 0 && fail_cnt == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/ibus_if.sv
hw/pc_gen.sv
hw/fetch_ctrl.sv
hw/branch_predict_buf.sv
hw/instr_fetch.sv
hw/fetch_top.sv
verification/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_front_end

export_include_dirs:
  - hw

sources:
  - hw/fetch_pkg.sv
  - hw/ibus_if.sv
  - hw/pc_gen.sv
  - hw/fetch_ctrl.sv
  - hw/branch_predict_buf.sv
  - hw/instr_fetch.sv
  - hw/fetch_top.sv
  - target: simulation
    files:
      - verification/tb_fetch_top.sv
